// ==== verilog/mpu_pkg.sv ====
package mpu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Physical memory attributes
  //////////////////////////////////////////////////////////////////////

  // Bounds are word addresses, low inclusive and high exclusive
  typedef struct packed {
    logic [29:0] word_addr_low;
    logic [29:0] word_addr_high;
    logic        main;
    logic        bufferable;
    logic        cacheable;
    logic        atomic;
  } pma_region_t;

  localparam int PMA_NUM_REGIONS = 4;

  // Attributes of an address that hits no region
  localparam pma_region_t PMA_R_DEFAULT = '{
    word_addr_low:  30'h0,
    word_addr_high: 30'h0,
    main:           1'b0,
    bufferable:     1'b0,
    cacheable:      1'b0,
    atomic:         1'b0
  };

  // Region table, the lowest index wins where regions overlap
  localparam pma_region_t PMA_CFG [PMA_NUM_REGIONS] = '{
    // 0x1000 to 0x2000, main with atomics, bufferable
    '{word_addr_low: 30'h0000_0400, word_addr_high: 30'h0000_0800,
      main: 1'b1, bufferable: 1'b1, cacheable: 1'b0, atomic: 1'b1},
    // 0x1000 to 0x8000, main and cacheable, no atomics
    '{word_addr_low: 30'h0000_0400, word_addr_high: 30'h0000_2000,
      main: 1'b1, bufferable: 1'b0, cacheable: 1'b1, atomic: 1'b0},
    // 0x8000 to 0x9000, peripheral I/O
    '{word_addr_low: 30'h0000_2000, word_addr_high: 30'h0000_2400,
      main: 1'b0, bufferable: 1'b0, cacheable: 1'b0, atomic: 1'b0},
    // 0xA000 to 0xC000, main, bufferable and cacheable
    '{word_addr_low: 30'h0000_2800, word_addr_high: 30'h0000_3000,
      main: 1'b1, bufferable: 1'b1, cacheable: 1'b1, atomic: 1'b1}
  };

  //////////////////////////////////////////////////////////////////////
  // MPU control and bus side
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    MPU_IDLE       = 2'b00,
    MPU_WAIT_DRAIN = 2'b01,
    MPU_ERR_RESP   = 2'b10
  } mpu_state_e;

  // Bus transactions granted but still waiting for rvalid
  localparam int MAX_OUTSTANDING = 2;
  localparam int OUTST_W         = 2;

  // OBI memtype: bit 0 bufferable, bit 1 cacheable

endpackage

// ==== verilog/mpu_trans_if.sv ====
`timescale 1ns/1ps

// One core transaction on its way from the MPU to the OBI side
interface mpu_trans_if;

  logic        valid;
  logic        ready;
  logic [31:0] addr;
  logic [1:0]  memtype;

  // MPU controller side
  modport ctrl (
    output valid,
    output addr,
    output memtype,
    input  ready
  );

  // Bus adapter side
  modport bus (
    input  valid,
    input  addr,
    input  memtype,
    output ready
  );

endinterface

// ==== verilog/pma_lookup.sv ====
`timescale 1ns/1ps

module pma_lookup (
  input  logic [31:0]         addr_i,
  input  logic                exec_i,
  input  logic                atomic_i,
  input  logic                misaligned_i,
  output mpu_pkg::pma_region_t cfg_o,
  output logic                fault_o
);

  logic [mpu_pkg::PMA_NUM_REGIONS-1:0] region_hit;
  logic                                match;
  mpu_pkg::pma_region_t                cfg_sel;
  logic                                exec_fault;
  logic                                misaligned_fault;
  logic                                atomic_fault;

  //////////////////////////////////////////////////////////////////////
  // Region search
  //////////////////////////////////////////////////////////////////////

  // Word bounds are scaled up to byte addresses before the compare
  always_comb begin
    for (int i = 0; i < mpu_pkg::PMA_NUM_REGIONS; i++) begin
      region_hit[i] = ({mpu_pkg::PMA_CFG[i].word_addr_low, 2'b00} <= addr_i) &&
                      (addr_i < {mpu_pkg::PMA_CFG[i].word_addr_high, 2'b00});
    end
  end

  // First hit from index 0 up takes the region
  always_comb begin
    match   = 1'b0;
    cfg_sel = mpu_pkg::PMA_R_DEFAULT;
    for (int i = 0; i < mpu_pkg::PMA_NUM_REGIONS; i++) begin
      if (!match && region_hit[i]) begin
        match   = 1'b1;
        cfg_sel = mpu_pkg::PMA_CFG[i];
      end
    end
  end

  assign cfg_o = cfg_sel;

  //////////////////////////////////////////////////////////////////////
  // Access checks
  //////////////////////////////////////////////////////////////////////

  // Code only runs from main memory
  assign exec_fault = exec_i && !cfg_sel.main;

  // I/O regions take naturally aligned accesses only
  assign misaligned_fault = misaligned_i && !cfg_sel.main;

  assign atomic_fault = atomic_i && !cfg_sel.atomic;

  assign fault_o = exec_fault || misaligned_fault || atomic_fault;

endmodule

// ==== verilog/mpu_ctrl.sv ====
`timescale 1ns/1ps

module mpu_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,

  // Core request
  input  logic                 core_valid_i,
  output logic                 core_ready_o,
  input  logic [31:0]          core_addr_i,

  // From the PMA lookup
  input  mpu_pkg::pma_region_t cfg_i,
  input  logic                 fault_i,

  // From and to the bus adapter
  input  logic                 outstanding_zero_i,
  output logic                 err_resp_valid_o,
  mpu_trans_if.ctrl            trans
);

  mpu_pkg::mpu_state_e state_q;
  mpu_pkg::mpu_state_e state_d;

  logic block_core;
  logic block_bus;
  logic err_accept;

  //////////////////////////////////////////////////////////////////////
  // Blocking
  //////////////////////////////////////////////////////////////////////

  // Core waits while an error is pending or being returned
  assign block_core = (state_q != mpu_pkg::MPU_IDLE);

  // Bus never sees a refused request or anything behind it
  assign block_bus = fault_i || (state_q != mpu_pkg::MPU_IDLE);

  // Refused request is taken from the core without a bus cycle
  assign err_accept = core_valid_i && fault_i && !block_core;

  //////////////////////////////////////////////////////////////////////
  // Transaction towards the bus adapter
  //////////////////////////////////////////////////////////////////////

  assign trans.valid   = core_valid_i && !block_bus;
  assign trans.addr    = core_addr_i;
  assign trans.memtype = {cfg_i.cacheable, cfg_i.bufferable};

  // Allowed requests complete on the bus grant, refused ones at once
  always_comb begin
    core_ready_o = 1'b0;
    if (!block_core) begin
      if (fault_i) begin
        core_ready_o = core_valid_i;
      end else begin
        core_ready_o = trans.ready;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Error FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d          = state_q;
    err_resp_valid_o = 1'b0;

    case (state_q)
      mpu_pkg::MPU_IDLE: begin
        if (err_accept) begin
          state_d = mpu_pkg::MPU_WAIT_DRAIN;
        end
      end

      // Older bus responses must reach the core first
      mpu_pkg::MPU_WAIT_DRAIN: begin
        if (outstanding_zero_i) begin
          state_d = mpu_pkg::MPU_ERR_RESP;
        end
      end

      // Single cycle error response, bus is quiet here
      mpu_pkg::MPU_ERR_RESP: begin
        err_resp_valid_o = 1'b1;
        state_d          = mpu_pkg::MPU_IDLE;
      end

      default: begin
        state_d = mpu_pkg::MPU_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= mpu_pkg::MPU_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== verilog/obi_adapter.sv ====
`timescale 1ns/1ps

module obi_adapter (
  input  logic        clk,
  input  logic        rst_n,

  // From the MPU controller
  mpu_trans_if.bus    trans,
  input  logic        err_resp_valid_i,
  output logic        outstanding_zero_o,

  // OBI request and response
  output logic        obi_req_o,
  input  logic        obi_gnt_i,
  output logic [31:0] obi_addr_o,
  output logic [1:0]  obi_memtype_o,
  input  logic        obi_rvalid_i,

  // Core response
  output logic        core_resp_valid_o,
  output logic        core_resp_err_o
);

  logic [mpu_pkg::OUTST_W-1:0] outst_cnt_q;
  logic                        outst_full;
  logic                        bus_accept;

  //////////////////////////////////////////////////////////////////////
  // Request phase
  //////////////////////////////////////////////////////////////////////

  assign outst_full = (outst_cnt_q == mpu_pkg::OUTST_W'(mpu_pkg::MAX_OUTSTANDING));

  // No new request once the response slots are used up
  assign obi_req_o     = trans.valid && !outst_full;
  assign obi_addr_o    = trans.addr;
  assign obi_memtype_o = trans.memtype;

  assign bus_accept  = obi_req_o && obi_gnt_i;
  assign trans.ready = bus_accept;

  //////////////////////////////////////////////////////////////////////
  // Outstanding count
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outst_cnt_q <= '0;
    end else begin
      case ({bus_accept, obi_rvalid_i})
        2'b10:   outst_cnt_q <= outst_cnt_q + 1'b1;
        2'b01:   outst_cnt_q <= outst_cnt_q - 1'b1;
        default: outst_cnt_q <= outst_cnt_q;
      endcase
    end
  end

  // Last response arriving now already counts as drained
  assign outstanding_zero_o = (outst_cnt_q == '0) ||
                              ((outst_cnt_q == mpu_pkg::OUTST_W'(1)) && obi_rvalid_i);

  //////////////////////////////////////////////////////////////////////
  // Response merge
  //////////////////////////////////////////////////////////////////////

  // The FSM only answers after draining, so the two never collide
  assign core_resp_valid_o = obi_rvalid_i || err_resp_valid_i;
  assign core_resp_err_o   = err_resp_valid_i;

endmodule

// ==== verilog/mpu_top.sv ====
`timescale 1ns/1ps

module mpu_top (
  input  logic        clk,
  input  logic        rst_n,

  // Core request
  input  logic        core_valid_i,
  output logic        core_ready_o,
  input  logic [31:0] core_addr_i,
  input  logic        core_exec_i,
  input  logic        core_atomic_i,
  input  logic        core_misaligned_i,

  // Core response
  output logic        core_resp_valid_o,
  output logic        core_resp_err_o,

  // OBI
  output logic        obi_req_o,
  input  logic        obi_gnt_i,
  output logic [31:0] obi_addr_o,
  output logic [1:0]  obi_memtype_o,
  input  logic        obi_rvalid_i
);

  mpu_pkg::pma_region_t pma_cfg;
  logic                 pma_fault;
  logic                 err_resp_valid;
  logic                 outstanding_zero;

  mpu_trans_if trans_if ();

  pma_lookup i_pma_lookup (
    .addr_i       (core_addr_i),
    .exec_i       (core_exec_i),
    .atomic_i     (core_atomic_i),
    .misaligned_i (core_misaligned_i),
    .cfg_o        (pma_cfg),
    .fault_o      (pma_fault)
  );

  mpu_ctrl i_mpu_ctrl (
    .clk                (clk),
    .rst_n              (rst_n),
    .core_valid_i       (core_valid_i),
    .core_ready_o       (core_ready_o),
    .core_addr_i        (core_addr_i),
    .cfg_i              (pma_cfg),
    .fault_i            (pma_fault),
    .outstanding_zero_i (outstanding_zero),
    .err_resp_valid_o   (err_resp_valid),
    .trans              (trans_if.ctrl)
  );

  obi_adapter i_obi_adapter (
    .clk                (clk),
    .rst_n              (rst_n),
    .trans              (trans_if.bus),
    .err_resp_valid_i   (err_resp_valid),
    .outstanding_zero_o (outstanding_zero),
    .obi_req_o          (obi_req_o),
    .obi_gnt_i          (obi_gnt_i),
    .obi_addr_o         (obi_addr_o),
    .obi_memtype_o      (obi_memtype_o),
    .obi_rvalid_i       (obi_rvalid_i),
    .core_resp_valid_o  (core_resp_valid_o),
    .core_resp_err_o    (core_resp_err_o)
  );

endmodule

// ==== tests/mpu_checker.sv ====
`timescale 1ns/1ps

module mpu_checker (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] core_addr_i,
  input  logic        core_exec_i,
  input  logic        core_atomic_i,
  input  logic        core_misaligned_i,
  input  logic        obi_req_i,
  input  logic        obi_gnt_i,
  input  logic [31:0] obi_addr_i,
  input  logic [1:0]  obi_memtype_i,
  input  logic        obi_rvalid_i,
  output logic        error_o
);

  mpu_pkg::pma_region_t exp_cfg;
  logic                 exp_fault;
  logic                 wait_q;
  logic [31:0]          addr_q;
  int                   outst;

  // Walk down from the top entry so the lowest matching index is kept
  always_comb begin
    exp_cfg = mpu_pkg::PMA_R_DEFAULT;
    for (int i = mpu_pkg::PMA_NUM_REGIONS - 1; i >= 0; i--) begin
      if (core_addr_i[31:2] >= mpu_pkg::PMA_CFG[i].word_addr_low &&
          core_addr_i[31:2] <  mpu_pkg::PMA_CFG[i].word_addr_high) begin
        exp_cfg = mpu_pkg::PMA_CFG[i];
      end
    end
  end

  assign exp_fault = ((core_exec_i || core_misaligned_i) && !exp_cfg.main) ||
                     (core_atomic_i && !exp_cfg.atomic);

  task automatic report(input string msg);
    $display("Fail at %0t: %s", $time, msg);
    error_o <= 1'b1;
  endtask

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wait_q  <= 1'b0;
      addr_q  <= '0;
      outst   <= 0;
      error_o <= 1'b0;
    end else begin
      if (obi_req_i && obi_memtype_i != {exp_cfg.cacheable, exp_cfg.bufferable}) begin
        report("obi_memtype_o does not match the expected region");
      end
      if (obi_req_i && exp_fault) begin
        report("obi_req_o raised for a request that should fault");
      end
      if (wait_q && (!obi_req_i || obi_addr_i != addr_q)) begin
        report("obi request dropped or address changed before grant");
      end
      if (obi_rvalid_i && outst == 0) begin
        report("obi_rvalid_i without an outstanding request");
      end
      if (obi_req_i && obi_gnt_i && !obi_rvalid_i && outst == mpu_pkg::MAX_OUTSTANDING) begin
        report("more bus transactions outstanding than allowed");
      end
      wait_q <= obi_req_i && !obi_gnt_i;
      addr_q <= obi_addr_i;
      outst  <= outst + int'(obi_req_i && obi_gnt_i) - int'(obi_rvalid_i);
    end
  end

endmodule

// ==== tests/tb_mpu.sv ====
`timescale 1ns/1ps

module tb_mpu;

  localparam int TIMEOUT = 200;

  logic        clk = 1'b0;
  logic        rst_n = 1'b0;
  logic        core_valid = 1'b0;
  logic [31:0] core_addr = '0;
  logic        core_exec = 1'b0;
  logic        core_atomic = 1'b0;
  logic        core_misaligned = 1'b0;
  logic        obi_gnt = 1'b0;
  logic        obi_rvalid = 1'b0;
  logic        core_ready;
  logic        core_resp_valid;
  logic        core_resp_err;
  logic        obi_req;
  logic [31:0] obi_addr;
  logic [1:0]  obi_memtype;
  logic        chk_error;

  // Memory model controls and bookkeeping
  logic        gnt_block = 1'b0;
  logic        rsp_block = 1'b0;
  int          gnt_wait;
  int          cyc;
  int          rsp_due[$];
  logic        resp_q[$];
  logic [31:0] bus_addr_q[$];
  logic [1:0]  bus_mt_q[$];
  int          req_cycles = 0;

  mpu_top i_dut (
    .clk (clk), .rst_n (rst_n),
    .core_valid_i (core_valid), .core_ready_o (core_ready), .core_addr_i (core_addr),
    .core_exec_i (core_exec), .core_atomic_i (core_atomic),
    .core_misaligned_i (core_misaligned),
    .core_resp_valid_o (core_resp_valid), .core_resp_err_o (core_resp_err),
    .obi_req_o (obi_req), .obi_gnt_i (obi_gnt), .obi_addr_o (obi_addr),
    .obi_memtype_o (obi_memtype), .obi_rvalid_i (obi_rvalid)
  );

  mpu_checker i_checker (
    .clk (clk), .rst_n (rst_n), .core_addr_i (core_addr), .core_exec_i (core_exec),
    .core_atomic_i (core_atomic), .core_misaligned_i (core_misaligned),
    .obi_req_i (obi_req), .obi_gnt_i (obi_gnt), .obi_addr_i (obi_addr),
    .obi_memtype_i (obi_memtype), .obi_rvalid_i (obi_rvalid), .error_o (chk_error)
  );

  initial begin
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Memory responder with random grant and response delays
  //////////////////////////////////////////////////////////////////////

  // Grant after 0 to 3 cycles, rvalid 1 to 3 cycles after the grant
  initial begin
    void'($urandom(32'h5691));
    forever begin
      @(posedge clk);
      if (!rst_n) begin
        cyc      = 0;
        gnt_wait = 0;
        rsp_due.delete();
        obi_gnt    <= 1'b0;
        obi_rvalid <= 1'b0;
      end else begin
        cyc++;
        if (obi_req && obi_gnt) begin
          rsp_due.push_back(cyc + int'($urandom % 3));
          gnt_wait = int'($urandom % 4);
        end else if (obi_req && gnt_wait > 0) begin
          gnt_wait--;
        end
        obi_gnt    <= !gnt_block && (gnt_wait == 0);
        obi_rvalid <= 1'b0;
        if (!rsp_block && rsp_due.size() > 0 && rsp_due[0] <= cyc) begin
          obi_rvalid <= 1'b1;
          void'(rsp_due.pop_front());
        end
      end
    end
  end

  // Outputs are sampled mid-cycle where they have settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (core_resp_valid) resp_q.push_back(core_resp_err);
      if (obi_req) req_cycles++;
      if (obi_req && obi_gnt) begin
        bus_addr_q.push_back(obi_addr);
        bus_mt_q.push_back(obi_memtype);
      end
    end
  end

  always @(posedge clk) begin
    if (chk_error) begin
      $display("=== FAIL ===");
      $fatal(1, "Bus checker found a protocol violation");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string msg);
    if (actual !== expected) begin
      $display("Fail at %0t: %s (got %0h, expected %0h)", $time, msg, actual, expected);
      $display("=== FAIL ===");
      $fatal(1, "Value check failed");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t: %s never came within %0d cycles", $time, what, TIMEOUT);
    $display("=== FAIL ===");
    $fatal(1, "Wait timed out");
  endtask

  task automatic drive_req(input logic [31:0] addr, input logic exec, atomic, mis);
    @(posedge clk);
    core_valid      <= 1'b1;
    core_addr       <= addr;
    core_exec       <= exec;
    core_atomic     <= atomic;
    core_misaligned <= mis;
  endtask

  // Returns on the edge that closes the handshake cycle
  task automatic wait_ready(input string what);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) report_timeout(what);
    end while (!core_ready);
  endtask

  task automatic send_req(input logic [31:0] addr, input logic exec, atomic, mis);
    drive_req(addr, exec, atomic, mis);
    wait_ready("core_ready_o for a request");
    core_valid <= 1'b0;
  endtask

  task automatic wait_resp(input int count);
    int n;
    n = 0;
    while (resp_q.size() < count) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) report_timeout("core response");
    end
  endtask

  // One access gives one response and a bus transfer only when allowed
  task automatic check_access(input logic [31:0] addr, input logic exec, atomic, mis,
                              input logic fault, input logic [1:0] mt, input string name);
    int nresp;
    int nbus;
    int nreq;
    nresp = resp_q.size();
    nbus  = bus_addr_q.size();
    nreq  = req_cycles;
    send_req(addr, exec, atomic, mis);
    wait_resp(nresp + 1);
    repeat (4) @(posedge clk);
    check_eq(resp_q.size(), nresp + 1, {name, ": number of responses"});
    check_eq(32'(resp_q[nresp]), 32'(fault), {name, ": response error flag"});
    if (fault) begin
      check_eq(bus_addr_q.size(), nbus, {name, ": bus transfer for a fault"});
      check_eq(req_cycles, nreq, {name, ": obi_req_o raised for a fault"});
    end else begin
      check_eq(bus_addr_q.size(), nbus + 1, {name, ": bus transfers"});
      check_eq(bus_addr_q[nbus], addr, {name, ": bus address"});
      check_eq(32'(bus_mt_q[nbus]), 32'(mt), {name, ": bus memtype"});
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_allowed_reads();
    check_access(32'h0000_1000, 0, 0, 0, 0, 2'b01, "region 0 read");
    check_access(32'h0000_4000, 0, 0, 0, 0, 2'b10, "region 1 read");
    check_access(32'h0000_8004, 0, 0, 0, 0, 2'b00, "region 2 read");
    check_access(32'h0000_A100, 0, 0, 0, 0, 2'b11, "region 3 read");
  endtask

  task automatic test_lowest_match();
    check_access(32'h0000_1800, 0, 1, 0, 0, 2'b01, "atomic in region 0");
    check_access(32'h0000_3000, 0, 1, 0, 1, 2'b00, "atomic in region 1");
  endtask

  task automatic test_exec_faults();
    check_access(32'h0000_8000, 1, 0, 0, 1, 2'b00, "execute from I/O");
    check_access(32'h0000_F000, 1, 0, 0, 1, 2'b00, "execute from unmapped");
  endtask

  task automatic test_misaligned();
    check_access(32'h0000_8002, 0, 0, 1, 1, 2'b00, "misaligned to I/O");
    check_access(32'h0000_A002, 0, 0, 1, 0, 2'b11, "misaligned to region 3");
  endtask

  task automatic test_error_order();
    int nresp;
    nresp = resp_q.size();
    @(posedge clk);
    rsp_block <= 1'b1;
    send_req(32'h0000_A000, 0, 0, 0);
    send_req(32'h0000_A010, 0, 0, 0);
    send_req(32'h0000_8000, 1, 0, 0);
    repeat (10) @(posedge clk);
    check_eq(resp_q.size(), nresp, "response while bus responses are held");
    drive_req(32'h0000_A020, 0, 0, 0);
    rsp_block <= 1'b0;
    wait_ready("core_ready_o after the error response");
    core_valid <= 1'b0;
    check_eq(resp_q.size(), nresp + 3, "request taken before the error response");
    wait_resp(nresp + 4);
    check_eq(32'(resp_q[nresp]), 0, "first bus response error flag");
    check_eq(32'(resp_q[nresp + 1]), 0, "second bus response error flag");
    check_eq(32'(resp_q[nresp + 2]), 1, "error response out of order");
    check_eq(32'(resp_q[nresp + 3]), 0, "response after the error");
  endtask

  task automatic test_back_pressure();
    int nresp;
    nresp = resp_q.size();
    @(posedge clk);
    gnt_block <= 1'b1;
    drive_req(32'h0000_A040, 0, 0, 0);
    repeat (20) begin
      @(posedge clk);
      check_eq(32'(obi_req), 1, "obi_req_o while grant is held");
      check_eq(obi_addr, 32'h0000_A040, "obi_addr_o while grant is held");
      check_eq(32'(core_ready), 0, "core_ready_o while grant is held");
    end
    gnt_block <= 1'b0;
    wait_ready("core_ready_o after the grant is released");
    core_valid <= 1'b0;
    // Bus is drained before the two slots are filled
    wait_resp(nresp + 1);
    // Third request against two outstanding
    rsp_block <= 1'b1;
    send_req(32'h0000_A050, 0, 0, 0);
    send_req(32'h0000_A060, 0, 0, 0);
    drive_req(32'h0000_A070, 0, 0, 0);
    repeat (10) begin
      @(posedge clk);
      check_eq(32'(obi_req), 0, "obi_req_o with the outstanding count full");
      check_eq(32'(core_ready), 0, "core_ready_o with the outstanding count full");
    end
    rsp_block <= 1'b0;
    wait_ready("core_ready_o after a bus response frees a slot");
    core_valid <= 1'b0;
    wait_resp(nresp + 4);
  endtask

  initial begin
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    test_allowed_reads();
    test_lowest_match();
    test_exec_faults();
    test_misaligned();
    test_error_order();
    test_back_pressure();
    repeat (5) @(posedge clk);
    @(negedge clk);
    if (chk_error) begin
      $display("=== FAIL ===");
      $fatal(1, "Bus checker found a protocol violation");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

// ==== flist.f ====
verilog/mpu_pkg.sv
verilog/mpu_trans_if.sv
verilog/pma_lookup.sv
verilog/mpu_ctrl.sv
verilog/obi_adapter.sv
verilog/mpu_top.sv
tests/mpu_checker.sv
tests/tb_mpu.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module tb_mpu -f flist.f

run: build
	-./obj_dir/Vtb_mpu > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG) || ! grep -q "=== PASS ===" $(LOG); then \
	  echo "Simulation failed"; exit 1; \
	fi
	@echo "Simulation passed"

lint:
	verilator --lint-only --timing --top-module tb_mpu -f flist.f

clean:
	rm -rf obj_dir $(LOG)
